//--- logic/psuSwPkg.sv
// every delay counts iClk cycles and must be at least 1 and below 2**19

package psuSwPkg;

   // ####################
   // sleep state encoding
   // ####################

   // three bits cover all eight states so no encoding is left unused
   typedef enum logic [2:0] {
      init   = 3'd0,   // after reset, waits for a deep sleep indication
      s4     = 3'd1,   // deep sleep with all rails off, strap high
      s4p    = 3'd2,   // deep sleep keeping memory on standby, strap low
      s3     = 3'd3,   // suspend to ram, memory on standby
      s0     = 3'd4,   // platform awake, waiting for power good
      s0hold = 3'd5,   // crossover, both memory switches on
      s0on   = 3'd6,   // main power only
      s4hold = 3'd7    // memory off drain before standby
   } switchState_t;

   // ####################
   // timer counts
   // ####################

   // wide enough for the longest default delay (400000 < 524288)
   localparam int timerWidth = 19;

   typedef logic [timerWidth-1:0] timerCount_t;   // unsigned count

   // ####################
   // default delays
   // ####################

   // crossover ramp before main only
   localparam timerCount_t defRampDelayCycles = timerCount_t'(100000);

   // wait in s0hold before starting the memory drain
   localparam timerCount_t defExitDelayCycles = timerCount_t'(400000);

   // memory switch off time before standby again
   localparam timerCount_t defMemOffDelayCycles = timerCount_t'(3000);

   // the top level forwards these as its parameter defaults
   // and a simulation build overrides them with short values

endpackage

//--- logic/switchTimerIf.sv
// plain levels without handshake; a done level means nothing while its enable is low
`timescale 1ns/1ps

interface switchTimerIf;

   // ####################
   // requests from fsm
   // ####################
   logic holdTimerEn;     // high only in s0hold
   logic memOffTimerEn;   // high only in s4hold

   // ####################
   // results from timers
   // ####################
   logic rampDone;        // ramp delay elapsed since s0hold entry
   logic exitDone;        // exit delay elapsed since s0hold entry
   logic memOffDone;      // memory off delay elapsed since s4hold entry

   // state machine side
   modport fsm (
      output holdTimerEn,
      output memOffTimerEn,
      input  rampDone,
      input  exitDone,
      input  memOffDone
   );

   // counter side
   modport timers (
      input  holdTimerEn,
      input  memOffTimerEn,
      output rampDone,
      output exitDone,
      output memOffDone
   );

endinterface

//--- logic/switchDelayTimers.sv
// delays must be 1 or more; a done level is first sampled high delay edges after state entry
`timescale 1ns/1ps

module switchDelayTimers #(
   parameter psuSwPkg::timerCount_t rampDelayCycles   = psuSwPkg::defRampDelayCycles,
   parameter psuSwPkg::timerCount_t exitDelayCycles   = psuSwPkg::defExitDelayCycles,
   parameter psuSwPkg::timerCount_t memOffDelayCycles = psuSwPkg::defMemOffDelayCycles
) (
   input  logic iClk,
   input  logic iRst_n,        // async, active low
   switchTimerIf.timers tmr
);

   import psuSwPkg::*;

   // ####################
   // compare limits
   // ####################

   // count is cleared on the entry edge so the last count before the
   // sampling edge is one less than the delay
   localparam timerCount_t rampLimit   = rampDelayCycles - timerCount_t'(1);
   localparam timerCount_t exitLimit   = exitDelayCycles - timerCount_t'(1);
   localparam timerCount_t memOffLimit = memOffDelayCycles - timerCount_t'(1);

   // hold counter stops at whichever of its two compares is further out
   localparam timerCount_t holdSatLimit = (rampLimit > exitLimit) ? rampLimit : exitLimit;

   timerCount_t holdCnt;       // time spent in s0hold
   timerCount_t memOffCnt;     // time spent in s4hold

   // ####################
   // counters
   // ####################

   // ramp and exit share one counter since both start at the same s0hold entry
   always_ff @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n) begin
         holdCnt <= '0;
      end else if (!tmr.holdTimerEn) begin
         holdCnt <= '0;                               // idle until the next entry
      end else if (holdCnt < holdSatLimit) begin
         holdCnt <= holdCnt + timerCount_t'(1);
      end
   end

   always_ff @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n) begin
         memOffCnt <= '0;
      end else if (!tmr.memOffTimerEn) begin
         memOffCnt <= '0;
      end else if (memOffCnt < memOffLimit) begin
         memOffCnt <= memOffCnt + timerCount_t'(1);  // saturates at its limit
      end
   end

   // done masked by enable because the count stays stale for one cycle after exit
   assign tmr.rampDone   = tmr.holdTimerEn   && (holdCnt >= rampLimit);
   assign tmr.exitDone   = tmr.holdTimerEn   && (holdCnt >= exitLimit);
   assign tmr.memOffDone = tmr.memOffTimerEn && (memOffCnt >= memOffLimit);

   // ####################
   // checks
   // ####################

   // a done level stays up for as long as its enable does
   aDoneHolds : assert property (@(posedge iClk) disable iff (!iRst_n)
      (!$past(tmr.rampDone) || !tmr.holdTimerEn || tmr.rampDone) &&
      (!$past(tmr.exitDone) || !tmr.holdTimerEn || tmr.exitDone) &&
      (!$past(tmr.memOffDone) || !tmr.memOffTimerEn || tmr.memOffDone))
      else $error("timer done dropped while its enable stayed high");

   aCountSat : assert property (@(posedge iClk) disable iff (!iRst_n)
      (holdCnt <= holdSatLimit) && (memOffCnt <= memOffLimit))
      else $error("timer count past its saturation limit");

endmodule

//--- logic/sleepStateFsm.sv
// all inputs must be synchronous to iClk; switch enables are Moore outputs of the state register
`timescale 1ns/1ps

module sleepStateFsm (
   input  logic iClk,
   input  logic iRst_n,          // async, active low
   input  logic enable,          // low freezes the machine in most states
   input  logic psuPwrOk,        // supply power good
   input  logic slp3,            // sleep 3 indication, active high
   input  logic slp4,            // sleep 4 indication, active high
   input  logic dimmStbyStrap,   // high picks s4 and low picks s4p
   input  logic psuMainRdy,      // supply side ready to drop main
   input  logic fail,            // holds the deep sleep states
   switchTimerIf.fsm tmr,
   output logic auxSwEn,         // 12 V aux rail switch
   output logic stbySwEn,        // memory rail on 12 V standby
   output logic mainSwEn         // memory rail on 12 V main
);

   import psuSwPkg::*;

   switchState_t state;
   switchState_t nextState;

   logic anySleep;               // either sleep request present
   logic noSleep;                // platform asks for s0
   logic deepSleep;              // slp4 while supply is down

   assign anySleep  = slp3 | slp4;
   assign noSleep   = !slp3 && !slp4;
   assign deepSleep = !psuPwrOk && slp4;

   // ####################
   // state register
   // ####################

   always_ff @(posedge iClk or negedge iRst_n) begin
      if (!iRst_n) begin
         state <= init;
      end else begin
         state <= nextState;
      end
   end

   // ####################
   // next state
   // ####################

   // within each state the first matching test wins
   always_comb begin
      nextState = state;   // default is to stay
      case (state)
         init: begin
            if (!enable) begin
               nextState = init;                    // frozen
            end else if (deepSleep && dimmStbyStrap) begin
               nextState = s4;
            end else if (deepSleep && !dimmStbyStrap) begin
               nextState = s4p;
            end else begin
               nextState = init;
            end
         end

         s4: begin
            if (fail) begin
               nextState = s4;                      // fail hold
            end else if (!enable || (deepSleep && dimmStbyStrap)) begin
               nextState = s4;
            end else if (!psuPwrOk && !slp4) begin
               nextState = s3;
            end else begin
               nextState = init;                    // invalid combination
            end
         end

         // same as s4 with the strap test inverted
         s4p: begin
            if (fail) begin
               nextState = s4p;
            end else if (!enable || (deepSleep && !dimmStbyStrap)) begin
               nextState = s4p;
            end else if (!psuPwrOk && !slp4) begin
               nextState = s3;
            end else begin
               nextState = init;
            end
         end

         s3: begin
            if (slp3 && !slp4) begin
               nextState = s3;
            end else if (slp4 && dimmStbyStrap) begin
               nextState = s4;
            end else if (slp4 && !dimmStbyStrap) begin
               nextState = s4p;
            end else begin
               nextState = s0;                      // both sleeps low
            end
         end

         s0: begin
            if (!enable || (noSleep && !psuPwrOk)) begin
               nextState = s0;                      // wait for power good
            end else if (psuPwrOk && noSleep) begin
               nextState = s0hold;
            end else begin
               nextState = s3;                      // a sleep came back
            end
         end

         s0hold: begin
            if (psuPwrOk && noSleep && tmr.rampDone) begin
               nextState = s0on;
            end else if (anySleep && tmr.exitDone) begin
               nextState = s4hold;
            end else begin
               nextState = s0hold;
            end
         end

         s0on: begin
            if (!enable || (psuPwrOk && noSleep)) begin
               nextState = s0on;
            end else if (anySleep && psuMainRdy) begin
               nextState = s0hold;                  // back to crossover
            end else begin
               nextState = s0on;                    // supply not ready yet
            end
         end

         s4hold: begin
            nextState = tmr.memOffDone ? s3 : s4hold;
         end

         default: nextState = init;
      endcase
   end

   // ####################
   // outputs
   // ####################

   // decoded from the registered state only
   always_comb begin
      auxSwEn  = 1'b0;
      stbySwEn = 1'b0;
      mainSwEn = 1'b0;
      case (state)
         s4p, s3, s0, s4hold: stbySwEn = 1'b1;     // memory on standby
         s0hold: begin
            auxSwEn  = 1'b1;                        // both memory switches on
            stbySwEn = 1'b1;
            mainSwEn = 1'b1;
         end
         s0on: begin
            auxSwEn  = 1'b1;
            mainSwEn = 1'b1;
         end
         default: ;                                 // init and s4 keep all off
      endcase
   end

   assign tmr.holdTimerEn   = (state == s0hold);
   assign tmr.memOffTimerEn = (state == s4hold);

   // ####################
   // checks
   // ####################

   // memory rail moves between standby and main only through the crossover
   aMemCrossover : assert property (@(posedge iClk) disable iff (!iRst_n)
      (mainSwEn != $past(mainSwEn)) |-> (stbySwEn && $past(stbySwEn)))
      else $error("main switch changed without standby held on");

   aStateKnown : assert property (@(posedge iClk) disable iff (!iRst_n)
      !$isunknown(state))
      else $error("state register holds an unknown value");

   // hold states leave only on their own timer condition
   aHoldExit : assert property (@(posedge iClk) disable iff (!iRst_n)
      (state == s0hold) ##1 (state != s0hold) |->
         $past(tmr.rampDone && psuPwrOk && noSleep) || $past(tmr.exitDone && anySleep))
      else $error("s0hold left before its delay elapsed");

   aDrainExit : assert property (@(posedge iClk) disable iff (!iRst_n)
      (state == s4hold) ##1 (state != s4hold) |-> $past(tmr.memOffDone))
      else $error("s4hold left before memory off delay");

endmodule

//--- logic/psuSwitchCtrl.sv
// inputs must already be synchronized to iClk; all three delays are in clock cycles, minimum 1
`timescale 1ns/1ps

module psuSwitchCtrl #(
   // crossover time in s0hold before main only
   parameter psuSwPkg::timerCount_t rampDelayCycles   = psuSwPkg::defRampDelayCycles,
   // time in s0hold before the memory drain starts
   parameter psuSwPkg::timerCount_t exitDelayCycles   = psuSwPkg::defExitDelayCycles,
   // memory off time in s4hold
   parameter psuSwPkg::timerCount_t memOffDelayCycles = psuSwPkg::defMemOffDelayCycles
) (
   input  logic iClk,
   input  logic iRst_n,          // async, active low

   // ####################
   // platform inputs
   // ####################
   input  logic enable,          // master go, low freezes
   input  logic psuPwrOk,        // power good from supply
   input  logic slp3,            // sleep 3 level
   input  logic slp4,            // sleep 4 level
   input  logic dimmStbyStrap,   // board strap for deep sleep path
   input  logic psuMainRdy,      // supply ready to turn main off
   input  logic fail,            // keep rails off in deep sleep

   // ####################
   // switch enables
   // ####################
   output logic auxSwEn,         // 12 V aux switch
   output logic stbySwEn,        // memory on 12 V standby
   output logic mainSwEn         // memory on 12 V main
);

   // timer requests and done levels
   switchTimerIf tmrIf ();

   // state machine with Moore switch enables
   sleepStateFsm u_sleepStateFsm (
      .iClk          (iClk),
      .iRst_n        (iRst_n),
      .enable        (enable),
      .psuPwrOk      (psuPwrOk),
      .slp3          (slp3),
      .slp4          (slp4),
      .dimmStbyStrap (dimmStbyStrap),
      .psuMainRdy    (psuMainRdy),
      .fail          (fail),
      .tmr           (tmrIf.fsm),
      .auxSwEn       (auxSwEn),
      .stbySwEn      (stbySwEn),
      .mainSwEn      (mainSwEn)
   );

   // hold and memory off counters
   switchDelayTimers #(
      .rampDelayCycles   (rampDelayCycles),
      .exitDelayCycles   (exitDelayCycles),
      .memOffDelayCycles (memOffDelayCycles)
   ) u_switchDelayTimers (
      .iClk   (iClk),
      .iRst_n (iRst_n),
      .tmr    (tmrIf.timers)
   );

endmodule

//--- sim/tbClockGen.sv
// free running clock from time zero; reset is released by a rising edge after resetCycles edges
`timescale 1ns/1ps

module tbClockGen #(
   parameter int periodNs    = 4,   // full clock period in ns, even value
   parameter int resetCycles = 4    // rising edges seen with reset held
) (
   output logic iClk,
   output logic iRst_n               // async, active low
);

   // reset low from the very start, so the DUT never runs unreset
   initial begin
      iClk   = 1'b0;
      iRst_n = 1'b0;
      repeat (resetCycles) @(posedge iClk);
      iRst_n <= 1'b1;                // released on an edge, the DUT still sees it low there
   end

   always #(periodNs / 2) iClk = ~iClk;   // 2 ns high, 2 ns low

endmodule

//--- sim/psuSwitchCtrlTb.sv
// short delays of 8, 20 and 5 cycles and a fixed seed; run length and timeout count clock cycles
`timescale 1ns/1ps

module psuSwitchCtrlTb;

   import psuSwPkg::*;

   // ####################
   // run setup
   // ####################
   localparam int rampDly       = 8;     // edges from s0hold entry to s0on
   localparam int exitDly       = 20;    // edges from s0hold entry to s4hold
   localparam int memOffDly     = 5;     // edges from s4hold entry to s3
   localparam int numCycles     = 3000;
   localparam int timeoutCycles = numCycles + 200;

   logic iClk;
   logic iRst_n;
   logic enable, psuPwrOk, slp3, slp4, dimmStbyStrap, psuMainRdy, fail;
   logic auxSwEn, stbySwEn, mainSwEn;

   integer       seed;
   int           segLeft;               // cycles left in the current held segment
   int           cycleCnt;
   int           timeoutCnt;
   int           errCnt;
   int           checkCnt;
   switchState_t mState;                // model state
   int           holdAge;               // edges spent in s0hold since the entry edge
   int           drainAge;              // same for s4hold
   int           stateVisits [8];       // model cycles per state

   tbClockGen #(.periodNs(4), .resetCycles(4)) u_tbClockGen (
      .iClk   (iClk),
      .iRst_n (iRst_n)
   );

   psuSwitchCtrl #(
      .rampDelayCycles   (timerCount_t'(rampDly)),
      .exitDelayCycles   (timerCount_t'(exitDly)),
      .memOffDelayCycles (timerCount_t'(memOffDly))
   ) u_psuSwitchCtrl (
      .iClk          (iClk),
      .iRst_n        (iRst_n),
      .enable        (enable),
      .psuPwrOk      (psuPwrOk),
      .slp3          (slp3),
      .slp4          (slp4),
      .dimmStbyStrap (dimmStbyStrap),
      .psuMainRdy    (psuMainRdy),
      .fail          (fail),
      .auxSwEn       (auxSwEn),
      .stbySwEn      (stbySwEn),
      .mainSwEn      (mainSwEn)
   );

   // ####################
   // stimulus
   // ####################

   // high with a chance of one in oneIn
   function automatic logic drawBit(input int oneIn);
      drawBit = ($unsigned($random(seed)) % oneIn) == 0;
   endfunction

   // picks a pattern and holds it for 1 to 40 cycles
   task automatic drawSegment();
      int pick;
      pick    = $unsigned($random(seed)) % 100;
      segLeft = 1 + $unsigned($random(seed)) % 40;
      if (pick < 30) begin                       // platform wake with power good up
         slp3       <= 1'b0;
         slp4       <= 1'b0;
         psuPwrOk   <= 1'b1;
         psuMainRdy <= drawBit(2);
      end else if (pick < 55) begin              // sleep request while powered
         slp3       <= 1'b1;
         slp4       <= drawBit(2);
         psuPwrOk   <= 1'b1;
         psuMainRdy <= drawBit(2);
      end else if (pick < 80) begin              // power good drop with a possible deep sleep
         slp3          <= 1'b1;
         slp4          <= drawBit(2);
         psuPwrOk      <= 1'b0;
         dimmStbyStrap <= drawBit(2);
      end else begin                             // anything goes
         slp3          <= drawBit(2);
         slp4          <= drawBit(2);
         psuPwrOk      <= drawBit(2);
         psuMainRdy    <= drawBit(2);
         dimmStbyStrap <= drawBit(2);
      end
      enable <= !drawBit(16);                     // freeze now and then
      fail   <= drawBit(12);                      // rare
   endtask

   // ####################
   // reference model
   // ####################

   // one clock edge on the inputs the DUT samples at this edge
   task automatic stepModel();
      switchState_t nxt;
      logic noSleep;
      logic anySleep;
      logic deep;
      logic rampDone;
      logic exitDone;
      logic memOffDone;
      noSleep    = !slp3 && !slp4;
      anySleep   = slp3 || slp4;
      deep       = !psuPwrOk && slp4;               // deep sleep request
      rampDone   = (mState == s0hold) && (holdAge + 1 >= rampDly);
      exitDone   = (mState == s0hold) && (holdAge + 1 >= exitDly);
      memOffDone = (mState == s4hold) && (drainAge + 1 >= memOffDly);
      nxt        = mState;
      case (mState)
         init: if (enable && deep) nxt = dimmStbyStrap ? s4 : s4p;
         s4: if (!fail && enable && !(deep && dimmStbyStrap))
            nxt = (!psuPwrOk && !slp4) ? s3 : init;
         s4p: if (!fail && enable && !(deep && !dimmStbyStrap))
            nxt = (!psuPwrOk && !slp4) ? s3 : init;
         s3: if (!(slp3 && !slp4)) begin
            if (slp4) nxt = dimmStbyStrap ? s4 : s4p;
            else nxt = s0;                          // both sleeps low
         end
         s0: if (enable && !(noSleep && !psuPwrOk)) nxt = noSleep ? s0hold : s3;
         s0hold: begin
            if (psuPwrOk && noSleep && rampDone) nxt = s0on;
            else if (anySleep && exitDone) nxt = s4hold;
         end
         s0on: if (enable && !(psuPwrOk && noSleep) && anySleep && psuMainRdy) nxt = s0hold;
         s4hold: if (memOffDone) nxt = s3;
         default: nxt = init;
      endcase
      if (!iRst_n) begin
         mState   = init;
         holdAge  = 0;
         drainAge = 0;
      end else begin
         holdAge  = (mState == s0hold && nxt == s0hold) ? holdAge + 1 : 0;
         drainAge = (mState == s4hold && nxt == s4hold) ? drainAge + 1 : 0;
         mState   = nxt;
      end
      stateVisits[mState]++;
   endtask

   // switch table with bits in aux stby main order
   function automatic logic [2:0] expectedEnables(input switchState_t st);
      case (st)
         s4p, s3, s0, s4hold: expectedEnables = 3'b010;
         s0hold:              expectedEnables = 3'b111;   // crossover
         s0on:                expectedEnables = 3'b101;
         default:             expectedEnables = 3'b000;   // init and s4
      endcase
   endfunction

   // ####################
   // checks
   // ####################
   task automatic checkValue(input string name, input logic got, input logic expected);
      checkCnt++;
      if (got !== expected) begin
         errCnt++;
         $display("Error: %s is 0x%0h, expected 0x%0h (cycle %0d, model in %s)",
                  name, got, expected, cycleCnt, mState.name());
      end
   endtask

   task automatic checkOutputs();
      logic [2:0] exp;
      exp = expectedEnables(mState);
      checkValue("auxSwEn", auxSwEn, exp[2]);
      checkValue("stbySwEn", stbySwEn, exp[1]);
      checkValue("mainSwEn", mainSwEn, exp[0]);
   endtask

   // ####################
   // main sequence
   // ####################
   initial begin
      seed          = 32'h7f9f608d;
      enable        = 1'b1;
      psuPwrOk      = 1'b0;
      slp3          = 1'b0;
      slp4          = 1'b0;
      dimmStbyStrap = 1'b0;
      psuMainRdy    = 1'b0;
      fail          = 1'b0;
      mState        = init;
      holdAge       = 0;
      drainAge      = 0;
      segLeft       = 0;
      cycleCnt      = 0;
      errCnt        = 0;
      checkCnt      = 0;
      foreach (stateVisits[i]) stateVisits[i] = 0;
      while (cycleCnt < numCycles) begin
         @(posedge iClk);
         stepModel();                           // before the new inputs land
         if (segLeft == 0) drawSegment();
         segLeft--;
         @(negedge iClk);                       // outputs settled half a period later
         checkOutputs();
         cycleCnt++;
      end
      // a state the model never entered means the stimulus missed a behavior
      foreach (stateVisits[i]) begin
         if (stateVisits[i] == 0) begin
            errCnt++;
            $display("state code %0d was never reached by the stimulus", i);
         end
      end
      $display("summary: %0d checks, %0d errors", checkCnt, errCnt);
      if (errCnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog well past the end of the main loop
   initial begin
      timeoutCnt = 0;
      while (timeoutCnt < timeoutCycles) begin
         @(posedge iClk);
         timeoutCnt++;
      end
      $display("timeout: the run did not end within %0d clock cycles", timeoutCycles);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- files.f
logic/psuSwPkg.sv
logic/switchTimerIf.sv
logic/switchDelayTimers.sv
logic/sleepStateFsm.sv
logic/psuSwitchCtrl.sv
sim/tbClockGen.sv
sim/psuSwitchCtrlTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = psuSwitchCtrlTb
FILELIST = files.f

.PHONY: all compile run clean

all: run

# build the simulation executable into obj_dir
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# show the output and fail unless the pass line is in it
run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
